// ==== dac_pkg.sv ====
////////////////////////////////////////
// widths, register map and AD5601 frame layout for the DAC control block
// the word address is 4 bits wide so only 16 register slots can be decoded
////////////////////////////////////////

package dac_pkg;

    ////////////////////////////////////////
    // bus
    ////////////////////////////////////////

    localparam int BUS_DATA_W = 32;     // bus data and register width
    localparam int BUS_ADDR_W = 4;      // word address

    // version of this register layout, upper half of the version register
    localparam logic [15:0] MODULE_VERSION = 16'd1;

    // word addresses, anything from TOTAL_REGS upward is undefined
    typedef enum logic [BUS_ADDR_W-1:0] {
        ADDR_VERSION_ID  = 4'd0,    // ro
        ADDR_NUM_REGS    = 4'd1,    // ro, reads TOTAL_REGS
        ADDR_DAC_REG     = 4'd2,    // rw only with en_bus_ctrl high
        ADDR_EN_BUS_CTRL = 4'd3,    // ro mirror of the input
        TOTAL_REGS       = 4'd4
    } reg_addr_t;

    ////////////////////////////////////////
    // AD5601 frame
    ////////////////////////////////////////

    localparam int SPI_LEN = 16;        // bits per frame

    // gain lands in the data field
    localparam int GAIN_W   = 8;
    localparam int GAIN_LSB = 6;

    // frame layout
    //   [15:14] power-down mode
    //   [13:6]  data
    //   [5:0]   ignored by the DAC
    typedef logic [SPI_LEN-1:0] dac_word_t;

endpackage

// ==== dac_reg_map.sv ====
////////////////////////////////////////
// single-word register bus, no back-pressure, response always one cycle later
// the DAC register source follows en_bus_ctrl as sampled one cycle earlier
////////////////////////////////////////

`timescale 1ns/1ps

module dac_reg_map #(
    parameter logic [15:0] MODULE_ID   = 16'h0000,
    parameter logic [15:0] DAC_DEFAULT = 16'h0000
) (
    input  logic                               clk_ifc,
    input  logic                               SET_DEFAULT_ON_RESET,

    input  logic                               en_bus_ctrl,

    input  logic                               bus_write,
    input  logic                               bus_read,
    input  logic [dac_pkg::BUS_ADDR_W-1:0]     bus_addr,
    input  logic [dac_pkg::BUS_DATA_W-1:0]     bus_writedata,
    output logic [dac_pkg::BUS_DATA_W-1:0]     bus_readdata,
    output logic                               bus_readdatavalid,
    output logic                               bus_writeresponsevalid,
    output logic                               bus_error,

    input  logic [dac_pkg::GAIN_W-1:0]         gain_in,
    input  logic                               gain_valid,

    output dac_pkg::dac_word_t                 dac_word,
    output logic                               dac_req
);

    ////////////////////////////////////////
    // constants
    ////////////////////////////////////////

    localparam logic [dac_pkg::BUS_DATA_W-1:0] VERSION_ID = {dac_pkg::MODULE_VERSION, MODULE_ID};
    localparam logic [dac_pkg::BUS_DATA_W-1:0] NUM_REGS   = dac_pkg::TOTAL_REGS;

    ////////////////////////////////////////
    // signals
    ////////////////////////////////////////

    logic [dac_pkg::BUS_DATA_W-1:0] dac_reg;
    logic                           en_bus_ctrl_q;  // selects the DAC register source

    dac_pkg::reg_addr_t             addr;
    logic                           addr_undef;
    logic                           dac_wr_ok;      // accepted bus write to DAC_REG
    logic                           gain_ok;        // accepted gain strobe
    logic [dac_pkg::BUS_DATA_W-1:0] rd_mux;

    assign addr       = dac_pkg::reg_addr_t'(bus_addr);
    assign addr_undef = (bus_addr >= dac_pkg::TOTAL_REGS);

    // only one source may own the register at a time
    assign dac_wr_ok = bus_write && en_bus_ctrl_q && (addr == dac_pkg::ADDR_DAC_REG);
    assign gain_ok   = gain_valid && !en_bus_ctrl_q;

    assign dac_word = dac_reg[dac_pkg::SPI_LEN-1:0];

    ////////////////////////////////////////
    // read mux
    ////////////////////////////////////////

    always_comb begin
        case (addr)
            dac_pkg::ADDR_VERSION_ID:  rd_mux = VERSION_ID;
            dac_pkg::ADDR_NUM_REGS:    rd_mux = NUM_REGS;
            dac_pkg::ADDR_DAC_REG:     rd_mux = dac_reg;
            dac_pkg::ADDR_EN_BUS_CTRL: rd_mux = {{(dac_pkg::BUS_DATA_W-1){1'b0}}, en_bus_ctrl_q};
            default:                   rd_mux = '0;     // undefined, flagged by bus_error
        endcase
    end

    ////////////////////////////////////////
    // registers and responses
    ////////////////////////////////////////

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            dac_reg                <= {{(dac_pkg::BUS_DATA_W-16){1'b0}}, DAC_DEFAULT};
            en_bus_ctrl_q          <= 1'b0;
            bus_readdatavalid      <= 1'b0;
            bus_writeresponsevalid <= 1'b0;
            bus_error              <= 1'b0;
            dac_req                <= 1'b0;
        end else begin
            en_bus_ctrl_q          <= en_bus_ctrl;
            bus_readdatavalid      <= bus_read;
            bus_writeresponsevalid <= bus_write;
            bus_error              <= (bus_read || bus_write) && addr_undef;
            dac_req                <= dac_wr_ok || gain_ok;

            // writes to read-only addresses fall through silently
            if (dac_wr_ok) begin
                dac_reg <= bus_writedata;
            end else if (gain_ok) begin
                dac_reg[dac_pkg::GAIN_LSB +: dac_pkg::GAIN_W] <= gain_in;
            end
        end
    end

    // read data is only meaningful with bus_readdatavalid
    always_ff @(posedge clk_ifc) begin
        if (bus_read) begin
            bus_readdata <= rd_mux;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // the bus master never issues a read and a write in the same cycle
    a_no_rd_wr_overlap : assert property (
        @(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        !(bus_read && bus_write)
    ) else $error("bus_read and bus_write high together");

endmodule

// ==== dac_xfer_ctrl.sv ====
////////////////////////////////////////
// one frame after reset with the reset value of dac_word, then one per request
// requests during a frame collapse into a single follow-up frame
////////////////////////////////////////

`timescale 1ns/1ps

module dac_xfer_ctrl (
    input  logic               clk_ifc,
    input  logic               SET_DEFAULT_ON_RESET,

    input  dac_pkg::dac_word_t dac_word,
    input  logic               dac_req,

    output logic               spi_start,
    output dac_pkg::dac_word_t spi_tx,
    input  logic               spi_rdy,

    output logic               dac_updated,
    output logic               initdone
);

    typedef enum logic [1:0] {
        IDLE,
        START_AFTER_RESET,
        BUSY
    } state_t;

    state_t state;

    logic   rdy_prev;
    logic   rdy_rise;   // end of a frame
    logic   pending;    // request seen while a frame was in flight
    logic   launch;     // latch dac_word and raise spi_start

    assign rdy_rise = spi_rdy && !rdy_prev;

    always_comb begin
        case (state)
            IDLE:              launch = dac_req;
            START_AFTER_RESET: launch = 1'b1;
            BUSY:              launch = rdy_rise && (pending || dac_req);
            default:           launch = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // transfer FSM
    ////////////////////////////////////////

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            state       <= START_AFTER_RESET;   // default word goes out first
            spi_start   <= 1'b0;
            pending     <= 1'b0;
            rdy_prev    <= 1'b1;
            dac_updated <= 1'b0;
            initdone    <= 1'b0;
        end else begin
            rdy_prev    <= spi_rdy;
            dac_updated <= 1'b0;

            case (state)
                IDLE: begin
                    if (launch) begin
                        spi_start <= 1'b1;
                        state     <= BUSY;
                    end
                end

                START_AFTER_RESET: begin
                    spi_start <= 1'b1;
                    state     <= BUSY;
                    if (dac_req) begin
                        pending <= 1'b1;
                    end
                end

                BUSY: begin
                    // shifter has taken the word once rdy drops
                    if (spi_start && !spi_rdy) begin
                        spi_start <= 1'b0;
                    end

                    if (rdy_rise) begin
                        dac_updated <= 1'b1;
                        initdone    <= 1'b1;    // sticky after the first frame
                        if (launch) begin
                            spi_start <= 1'b1;
                            pending   <= 1'b0;
                        end else begin
                            state <= IDLE;
                        end
                    end else if (dac_req) begin
                        pending <= 1'b1;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // word for the shifter, held until the next launch
    always_ff @(posedge clk_ifc) begin
        if (launch) begin
            spi_tx <= dac_word;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // the shifter may still be loading, so the word must hold
    a_tx_stable : assert property (
        @(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        (spi_start && !spi_rdy) |-> $stable(spi_tx)
    ) else $error("spi_tx changed while a frame was starting");

endmodule

// ==== spi_shifter.sv ====
////////////////////////////////////////
// MSB first with SCLK idle high and sdi moving on rising SCLK for a falling-edge slave
// frame is 2*CLK_DIV*SPI_LEN cycles plus one setup and one hold cycle
////////////////////////////////////////

`timescale 1ns/1ps

module spi_shifter #(
    parameter int CLK_DIV = 2     // system cycles per SCLK half period
) (
    input  logic               clk_ifc,
    input  logic               SET_DEFAULT_ON_RESET,

    input  logic               spi_start,
    input  dac_pkg::dac_word_t spi_tx,
    output logic               spi_rdy,

    output logic               sclk,
    output logic               ssn,
    output logic               sdi
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int CNT_W = $clog2(dac_pkg::SPI_LEN + 1);

    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);
    localparam logic [CNT_W-1:0] BITS_ALL = CNT_W'(dac_pkg::SPI_LEN);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SETUP,    // ssn low while sclk is still high
        S_SHIFT,
        S_HOLD      // sclk high with ssn low one more cycle
    } sh_state_t;

    sh_state_t          state;
    logic [DIV_W-1:0]   div_cnt;
    logic [CNT_W-1:0]   bit_cnt;    // rising edges seen
    dac_pkg::dac_word_t shreg;
    logic               half_done;
    logic               load;
    logic               rise;

    assign half_done = (div_cnt == DIV_LAST);
    assign load      = (state == S_IDLE) && spi_start;
    assign rise      = (state == S_SHIFT) && half_done && !sclk;

    assign sdi = shreg[dac_pkg::SPI_LEN-1];

    ////////////////////////////////////////
    // frame sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            state   <= S_IDLE;
            spi_rdy <= 1'b1;
            ssn     <= 1'b1;
            sclk    <= 1'b1;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (load) begin
                        spi_rdy <= 1'b0;
                        ssn     <= 1'b0;
                        state   <= S_SETUP;
                    end
                end

                S_SETUP: begin
                    sclk    <= 1'b0;    // first falling edge where the slave takes the MSB
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= S_SHIFT;
                end

                S_SHIFT: begin
                    if (!half_done) begin
                        div_cnt <= div_cnt + 1'b1;
                    end else begin
                        div_cnt <= '0;
                        if (!sclk) begin
                            sclk    <= 1'b1;
                            bit_cnt <= bit_cnt + 1'b1;
                        end else if (bit_cnt == BITS_ALL) begin
                            state <= S_HOLD;    // last high half done
                        end else begin
                            sclk <= 1'b0;
                        end
                    end
                end

                default: begin  // S_HOLD
                    ssn     <= 1'b1;
                    spi_rdy <= 1'b1;
                    state   <= S_IDLE;
                end
            endcase
        end
    end

    // next bit shows up on the rising edge
    always_ff @(posedge clk_ifc) begin
        if (load) begin
            shreg <= spi_tx;
        end else if (rise) begin
            shreg <= {shreg[dac_pkg::SPI_LEN-2:0], 1'b0};
        end
    end

    // a select or clock edge without a busy shifter would cut a frame
    a_ssn_busy : assert property (
        @(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        (!ssn || !sclk) |-> !spi_rdy
    ) else $error("ssn or sclk active while spi_rdy high");

endmodule

// ==== dac_ad5601_ctrl.sv ====
////////////////////////////////////////
// AD5601 control with a register bus and a gain input
// DAC_DEFAULT is sent once after every reset before initdone rises
////////////////////////////////////////

`timescale 1ns/1ps

module dac_ad5601_ctrl #(
    parameter logic [15:0] MODULE_ID   = 16'h0000,
    parameter logic [15:0] DAC_DEFAULT = 16'h0000,  // [15:14] mode, [13:6] data
    parameter int          CLK_DIV     = 2
) (
    input  logic                           clk_ifc,
    input  logic                           SET_DEFAULT_ON_RESET,

    input  logic                           en_bus_ctrl,

    input  logic                           bus_write,
    input  logic                           bus_read,
    input  logic [dac_pkg::BUS_ADDR_W-1:0] bus_addr,
    input  logic [dac_pkg::BUS_DATA_W-1:0] bus_writedata,
    output logic [dac_pkg::BUS_DATA_W-1:0] bus_readdata,
    output logic                           bus_readdatavalid,
    output logic                           bus_writeresponsevalid,
    output logic                           bus_error,

    input  logic [dac_pkg::GAIN_W-1:0]     gain_in,
    input  logic                           gain_valid,

    output logic                           dac_updated,
    output logic                           initdone,

    output logic                           sclk,
    output logic                           ssn,
    output logic                           sdi
);

    dac_pkg::dac_word_t dac_word;
    logic               dac_req;
    logic               spi_start;
    dac_pkg::dac_word_t spi_tx;
    logic               spi_rdy;

    dac_reg_map #(
        .MODULE_ID   (MODULE_ID),
        .DAC_DEFAULT (DAC_DEFAULT)
    ) reg_map_i (
        .clk_ifc                (clk_ifc),
        .SET_DEFAULT_ON_RESET   (SET_DEFAULT_ON_RESET),
        .en_bus_ctrl            (en_bus_ctrl),
        .bus_write              (bus_write),
        .bus_read               (bus_read),
        .bus_addr               (bus_addr),
        .bus_writedata          (bus_writedata),
        .bus_readdata           (bus_readdata),
        .bus_readdatavalid      (bus_readdatavalid),
        .bus_writeresponsevalid (bus_writeresponsevalid),
        .bus_error              (bus_error),
        .gain_in                (gain_in),
        .gain_valid             (gain_valid),
        .dac_word               (dac_word),
        .dac_req                (dac_req)
    );

    dac_xfer_ctrl xfer_ctrl_i (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .dac_word             (dac_word),
        .dac_req              (dac_req),
        .spi_start            (spi_start),
        .spi_tx               (spi_tx),
        .spi_rdy              (spi_rdy),
        .dac_updated          (dac_updated),
        .initdone             (initdone)
    );

    spi_shifter #(
        .CLK_DIV (CLK_DIV)
    ) spi_i (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .spi_start            (spi_start),
        .spi_tx               (spi_tx),
        .spi_rdy              (spi_rdy),
        .sclk                 (sclk),
        .ssn                  (ssn),
        .sdi                  (sdi)
    );

endmodule

// ==== tb_clk_gen.sv ====
////////////////////////////////////////
// 100 ns clock, reset high for the first 10 rising edges
////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter realtime PERIOD     = 100ns,
    parameter int      RST_CYCLES = 10
) (
    output logic clk_ifc,
    output logic SET_DEFAULT_ON_RESET
);

    initial begin
        clk_ifc              = 1'b0;
        SET_DEFAULT_ON_RESET = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_ifc);
        @(negedge clk_ifc);
        SET_DEFAULT_ON_RESET = 1'b0;    // released on a falling edge like all stimulus
    end

    always #(PERIOD / 2) clk_ifc = ~clk_ifc;

endmodule

// ==== tb_dac_ctrl.sv ====
////////////////////////////////////////
// random bus and gain traffic checked against a register model and SPI receiver
////////////////////////////////////////

`timescale 1ns/1ps

module tb_dac_ctrl;

    localparam logic [15:0] MODULE_ID   = 16'h00A5;
    localparam logic [15:0] DAC_DEFAULT = 16'h4F40;
    localparam int          CLK_DIV     = 2;
    localparam int          NUM_FRAMES  = 15;   // 1 default + 6 bus + 6 gain + 2 merge
    localparam int CYCLE_LIMIT = NUM_FRAMES * (4 * CLK_DIV * dac_pkg::SPI_LEN + 20) + 2000;

    logic        clk_ifc, SET_DEFAULT_ON_RESET;
    logic        en_bus_ctrl, bus_write, bus_read, gain_valid;
    logic [3:0]  bus_addr;
    logic [31:0] bus_writedata, bus_readdata;
    logic        bus_readdatavalid, bus_writeresponsevalid, bus_error;
    logic [7:0]  gain_in;
    logic        dac_updated, initdone, sclk, ssn, sdi;

    logic [31:0] lcg_state = 32'h6ffd;
    logic [31:0] model_reg = {16'h0000, DAC_DEFAULT};   // reference DAC register
    logic [15:0] frame_q[$];                            // frames seen on the SPI pins
    logic [15:0] rx_shift;
    int          rx_bits = 0, rx_cnt = 0, upd_cnt = 0, cycle_cnt = 0;
    int          err_cnt = 0, test_cnt = 0, test_fail = 0, err_at_start = 0;
    logic        init_seen = 1'b0;
    string       cur_test = "none";

    tb_clk_gen clk_gen_i (.clk_ifc(clk_ifc), .SET_DEFAULT_ON_RESET(SET_DEFAULT_ON_RESET));

    dac_ad5601_ctrl #(
        .MODULE_ID (MODULE_ID), .DAC_DEFAULT (DAC_DEFAULT), .CLK_DIV (CLK_DIV)
    ) dut_i (
        .clk_ifc (clk_ifc), .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .en_bus_ctrl (en_bus_ctrl), .bus_write (bus_write), .bus_read (bus_read),
        .bus_addr (bus_addr), .bus_writedata (bus_writedata), .bus_readdata (bus_readdata),
        .bus_readdatavalid (bus_readdatavalid),
        .bus_writeresponsevalid (bus_writeresponsevalid), .bus_error (bus_error),
        .gain_in (gain_in), .gain_valid (gain_valid), .dac_updated (dac_updated),
        .initdone (initdone), .sclk (sclk), .ssn (ssn), .sdi (sdi)
    );

    ////////////////////////////////////////
    // monitors
    ////////////////////////////////////////

    // AD5601 receiver sampling on falling sclk
    always @(negedge sclk) begin
        if (!ssn) begin
            rx_shift = {rx_shift[14:0], sdi};
            rx_bits++;
            if (rx_bits == dac_pkg::SPI_LEN) begin
                frame_q.push_back(rx_shift);
                rx_cnt++;
                rx_bits = 0;
            end
        end
    end

    always @(posedge ssn) rx_bits = 0;     // drop a partial frame

    always @(posedge clk_ifc) begin
        if (dac_updated) upd_cnt++;         // value of the cycle just ended
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout, no progress after %0d cycles", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    always @(negedge clk_ifc) begin
        if (init_seen) require(initdone, "initdone fell after it had been set");
        if (initdone) init_seen = 1'b1;
        if (ssn) require(sclk, "sclk not idle high while ssn is high");
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] exp, act);
        assert (act === exp) else begin
            $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic require(input logic cond, input string msg);
        assert (cond === 1'b1) else begin
            $display("%s: %s", cur_test, msg);
            err_cnt++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test     = name;
        err_at_start = err_cnt;
    endtask

    task automatic end_test();
        test_cnt++;
        if (err_cnt == err_at_start) begin
            $display("[%s] passed", cur_test);
        end else begin
            test_fail++;
            $display("[%s] failed with %0d errors", cur_test, err_cnt - err_at_start);
        end
    endtask

    // one strobe with its response exactly one cycle later
    task automatic bus_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(negedge clk_ifc);
        bus_write     = wr;
        bus_read      = !wr;
        bus_addr      = addr;
        bus_writedata = wdata;
        @(negedge clk_ifc);
        bus_write = 1'b0;
        bus_read  = 1'b0;
        if (wr) require(bus_writeresponsevalid, "no write response one cycle after the strobe");
        else    require(bus_readdatavalid, "no read data valid one cycle after the strobe");
        rdata = bus_readdata;
        err   = bus_error;
        @(negedge clk_ifc);
        require(!bus_readdatavalid && !bus_writeresponsevalid, "response longer than one cycle");
    endtask

    task automatic set_bus_ctrl(input logic v);
        @(negedge clk_ifc);
        en_bus_ctrl = v;
        repeat (2) @(negedge clk_ifc);      // let the registered copy follow
    endtask

    task automatic wait_update();
        do @(negedge clk_ifc); while (!dac_updated);
        @(negedge clk_ifc);                 // counters settle
        compare_value("updates vs frames", rx_cnt, upd_cnt);
    endtask

    task automatic check_frame(input logic [15:0] exp);
        compare_value("frames queued", 1, frame_q.size());
        if (frame_q.size() > 0) compare_value("frame", exp, frame_q.pop_front());
    endtask

    task automatic check_readback();
        logic [31:0] rd;
        logic        err;
        bus_access(1'b0, dac_pkg::ADDR_DAC_REG, 32'h0, rd, err);
        compare_value("dac readback", model_reg, rd);
        compare_value("dac read error", 1'b0, err);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] rd, d, w0, w_last;
        logic        err;
        logic [3:0]  a;
        int          upd_before;

        en_bus_ctrl = 1'b0;
        bus_write = 1'b0;
        bus_read = 1'b0;
        bus_addr = '0;
        bus_writedata = '0;
        gain_in = '0;
        gain_valid = 1'b0;

        begin_test("reset_default");
        @(negedge clk_ifc);
        require(ssn && sclk && !dac_updated && !initdone, "SPI side not idle during reset");
        require(!bus_readdatavalid && !bus_writeresponsevalid, "bus responses active in reset");
        do begin
            @(negedge clk_ifc);
            if (!dac_updated) require(!initdone, "initdone high before the first frame ended");
        end while (!dac_updated);
        require(initdone, "initdone not high with the first dac_updated");
        @(negedge clk_ifc);
        check_frame(DAC_DEFAULT);
        end_test();

        begin_test("register_reads");
        bus_access(1'b0, dac_pkg::ADDR_VERSION_ID, 0, rd, err);
        compare_value("version", {dac_pkg::MODULE_VERSION, MODULE_ID}, rd);
        compare_value("version error", 1'b0, err);
        bus_access(1'b0, dac_pkg::ADDR_NUM_REGS, 0, rd, err);
        compare_value("num_regs", 32'd4, rd);
        compare_value("num_regs error", 1'b0, err);
        bus_access(1'b0, dac_pkg::ADDR_EN_BUS_CTRL, 0, rd, err);
        compare_value("en_bus_ctrl low", 32'd0, rd);
        compare_value("en_bus_ctrl low error", 1'b0, err);
        set_bus_ctrl(1'b1);
        bus_access(1'b0, dac_pkg::ADDR_EN_BUS_CTRL, 0, rd, err);
        compare_value("en_bus_ctrl high", 32'd1, rd);
        compare_value("en_bus_ctrl high error", 1'b0, err);
        check_readback();
        end_test();

        begin_test("bus_path");
        for (int i = 0; i < 6; i++) begin
            d = lcg_next();
            bus_access(1'b1, dac_pkg::ADDR_DAC_REG, d, rd, err);
            compare_value("write error", 1'b0, err);
            model_reg = d;
            wait_update();
            check_frame(d[15:0]);
        end
        set_bus_ctrl(1'b0);
        upd_before = upd_cnt;
        bus_access(1'b1, dac_pkg::ADDR_DAC_REG, lcg_next(), rd, err);   // must be ignored
        check_readback();
        repeat (200) @(negedge clk_ifc);
        compare_value("frames after locked write", 0, frame_q.size());
        compare_value("updates after locked write", upd_before, upd_cnt);
        end_test();

        begin_test("gain_path");
        for (int i = 0; i < 6; i++) begin
            d = lcg_next();
            @(negedge clk_ifc);
            gain_in    = d[15:8];
            gain_valid = 1'b1;
            @(negedge clk_ifc);
            gain_valid = 1'b0;
            model_reg[13:6] = d[15:8];
            wait_update();
            check_frame(model_reg[15:0]);
        end
        check_readback();
        end_test();

        begin_test("merging");
        set_bus_ctrl(1'b1);
        w0 = lcg_next();
        bus_access(1'b1, dac_pkg::ADDR_DAC_REG, w0, rd, err);
        do @(negedge clk_ifc); while (ssn);
        for (int k = 0; k < 3; k++) begin   // back to back writes one per cycle
            w_last = lcg_next();
            bus_write     = 1'b1;
            bus_addr      = dac_pkg::ADDR_DAC_REG;
            bus_writedata = w_last;
            @(negedge clk_ifc);
        end
        bus_write = 1'b0;
        model_reg = w_last;
        wait_update();
        check_frame(w0[15:0]);
        wait_update();
        repeat (300) @(negedge clk_ifc);
        require(frame_q.size() <= 1, "more than one frame after the merged writes");
        if (frame_q.size() > 0) compare_value("last frame", w_last[15:0], frame_q[$]);
        frame_q.delete();
        end_test();

        begin_test("errors");
        for (int i = 0; i < 4; i++) begin
            d = lcg_next();
            a = 4'(4 + d[7:0] % 12);
            bus_access(1'b0, a, 0, rd, err);
            compare_value("read error flag", 1'b1, err);
            bus_access(1'b1, a, lcg_next(), rd, err);
            compare_value("write error flag", 1'b1, err);
        end
        check_readback();
        repeat (50) @(negedge clk_ifc);
        compare_value("frames after bad accesses", 0, frame_q.size());
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
dac_pkg.sv
dac_reg_map.sv
dac_xfer_ctrl.sv
spi_shifter.sv
dac_ad5601_ctrl.sv
tb_clk_gen.sv
tb_dac_ctrl.sv
